// ==== ex_pkg.sv ====
//----------------------------------------
// constants, cause codes, enums and structs
// shared by the execute stage units
//----------------------------------------
`default_nettype none

package ex_pkg;

    localparam int XLEN      = 32;
    localparam int INS_BYTES = 4;

    // redirect target for every trap
    localparam logic [XLEN-1:0] TRAP_VECTOR = 32'h0000_0100;

    //----------------------------------------
    // trap causes
    //----------------------------------------
    localparam logic [XLEN-1:0] CAUSE_INS_ADDR_MISALIGNED   = 32'd0;
    localparam logic [XLEN-1:0] CAUSE_INS_ACCESS_FAULT      = 32'd1;
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INS           = 32'd2;
    localparam logic [XLEN-1:0] CAUSE_LOAD_ADDR_MISALIGNED  = 32'd4;
    localparam logic [XLEN-1:0] CAUSE_STORE_ADDR_MISALIGNED = 32'd6;
    localparam logic [XLEN-1:0] CAUSE_ECALL_M               = 32'd11;

    // load/store sizes that need alignment
    localparam logic [2:0] FUNCT3_HALF = 3'd1;
    localparam logic [2:0] FUNCT3_WORD = 3'd2;

    typedef enum logic [1:0] {
        ZONE_NONE,
        ZONE_REGFILE,
        ZONE_LOADQ,
        ZONE_STOREQ
    } ex_zone_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } ex_alu_op_e;

    //----------------------------------------
    // stage payloads
    //----------------------------------------
    typedef struct packed {
        logic             valid;
        logic             sof;
        logic             ferr;
        logic             uerr;
        logic             jump;
        logic             ecall;
        logic             cond;
        logic             link;
        ex_zone_e         zone;
        ex_alu_op_e       alu_op;
        logic [2:0]       funct3;
        logic [4:0]       regd_addr;
        logic [XLEN-1:0]  ins;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  operand_left;
        logic [XLEN-1:0]  operand_right;
        logic [XLEN-1:0]  cmp_left;
        logic [XLEN-1:0]  cmp_right;
        logic [XLEN-1:0]  regs2_data;
    } ex_ins_t;

    // sof is consumed at acceptance and is not held
    typedef struct packed {
        logic             valid;
        logic             ferr;
        logic             uerr;
        logic             jump;
        logic             ecall;
        logic             cond;
        logic             link;
        logic             lq_wr;
        logic             sq_wr;
        logic             regd_wr;
        logic [2:0]       funct3;
        logic [4:0]       regd_addr;
        logic [XLEN-1:0]  ins;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  pc_inc;
        logic [XLEN-1:0]  regs2_data;
    } ex_held_t;

    typedef struct packed {
        logic             wr;
        logic             cncl_load;
        logic [4:0]       addr;
        logic [XLEN-1:0]  data;
    } ex_wb_t;

    typedef struct packed {
        logic             lq_wr;
        logic             sq_wr;
        logic [2:0]       funct3;
        logic [4:0]       regd_addr;
        logic [XLEN-1:0]  addr;
        logic [XLEN-1:0]  data;
    } ex_lsq_req_t;

    typedef struct packed {
        logic             take;
        logic [XLEN-1:0]  cause;
        logic [XLEN-1:0]  value;
    } ex_trap_t;

endpackage

`default_nettype wire

// ==== ex_alu.sv ====
//----------------------------------------
// registered alu and branch compare
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  wire                         clk_i,
    input  wire                         resetb_i,
    input  wire                         en_i,
    input  wire ex_pkg::ex_alu_op_e     op_i,
    input  wire [ex_pkg::XLEN-1:0]      left_i,
    input  wire [ex_pkg::XLEN-1:0]      right_i,
    input  wire [ex_pkg::XLEN-1:0]      cmp_left_i,
    input  wire [ex_pkg::XLEN-1:0]      cmp_right_i,
    input  wire [2:0]                   funct3_i,
    output logic [ex_pkg::XLEN-1:0]     result_o,
    output logic                        cmp_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] result_d;
    logic            cmp_d;

    always_comb begin
        case (op_i)
            ALU_ADD: result_d = left_i + right_i;
            ALU_SUB: result_d = left_i - right_i;
            ALU_AND: result_d = left_i & right_i;
            ALU_OR:  result_d = left_i | right_i;
            ALU_XOR: result_d = left_i ^ right_i;
            ALU_SLT: result_d = {{(XLEN-1){1'b0}}, $signed(left_i) < $signed(right_i)};
            default: result_d = '0;
        endcase
    end

    // branch compare, coded as the branch funct3
    always_comb begin
        case (funct3_i)
            3'b000:  cmp_d = (cmp_left_i == cmp_right_i);
            3'b001:  cmp_d = (cmp_left_i != cmp_right_i);
            3'b100:  cmp_d = ($signed(cmp_left_i) <  $signed(cmp_right_i));
            3'b101:  cmp_d = ($signed(cmp_left_i) >= $signed(cmp_right_i));
            3'b110:  cmp_d = (cmp_left_i <  cmp_right_i);
            3'b111:  cmp_d = (cmp_left_i >= cmp_right_i);
            default: cmp_d = 1'b0;
        endcase
    end

    // lines up with the delay stage register
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            result_o <= '0;
            cmp_o    <= 1'b0;
        end else if (en_i) begin
            result_o <= result_d;
            cmp_o    <= cmp_d;
        end
    end

endmodule

`default_nettype wire

// ==== ex_delay_stage.sv ====
//----------------------------------------
// instruction register with zone decode
// and pc increment
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ex_delay_stage (
    input  wire                 clk_i,
    input  wire                 resetb_i,
    input  wire                 en_i,
    input  wire ex_pkg::ex_ins_t ins_i,
    output ex_pkg::ex_held_t    held_o
);
    import ex_pkg::*;

    ex_held_t held_d;
    ex_held_t payload_q;
    logic     valid_q;

    always_comb begin
        held_d            = '0;
        held_d.valid      = ins_i.valid;
        held_d.ferr       = ins_i.ferr;
        held_d.uerr       = ins_i.uerr;
        held_d.jump       = ins_i.jump;
        held_d.ecall      = ins_i.ecall;
        held_d.cond       = ins_i.cond;
        held_d.link       = ins_i.link;
        held_d.funct3     = ins_i.funct3;
        held_d.regd_addr  = ins_i.regd_addr;
        held_d.ins        = ins_i.ins;
        held_d.pc         = ins_i.pc;
        held_d.regs2_data = ins_i.regs2_data;
        // zone to one-hot write strobes
        case (ins_i.zone)
            ZONE_REGFILE: held_d.regd_wr = 1'b1;
            ZONE_LOADQ:   held_d.lq_wr   = 1'b1;
            ZONE_STOREQ:  held_d.sq_wr   = 1'b1;
            default:      held_d.regd_wr = 1'b0;
        endcase
        held_d.pc_inc = ins_i.pc + XLEN'(INS_BYTES);
    end

    //----------------------------------------
    // registers
    //----------------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            valid_q <= 1'b0;
        end else if (en_i) begin
            valid_q <= held_d.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            payload_q <= held_d;
        end
    end

    // valid comes from the reset register
    always_comb begin
        held_o       = payload_q;
        held_o.valid = valid_q;
    end

endmodule

`default_nettype wire

// ==== ex_trap_unit.sv ====
//----------------------------------------
// exception detect, cause priority and
// trap value select
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ex_trap_unit (
    input  wire ex_pkg::ex_held_t       held_i,
    input  wire                         ex_valid_i,
    input  wire [ex_pkg::XLEN-1:0]      alu_result_i,
    output ex_pkg::ex_trap_t            trap_o
);
    import ex_pkg::*;

    localparam int ALIGN_BITS = $clog2(INS_BYTES);

    logic ls_misaligned;
    logic excp_ferr;
    logic excp_uerr;
    logic excp_maif;
    logic excp_mala;
    logic excp_masa;
    logic excp_ecall;

    // address alignment by access size
    always_comb begin
        ls_misaligned = 1'b0;
        if (held_i.funct3 == FUNCT3_HALF) begin
            ls_misaligned = alu_result_i[0];
        end else if (held_i.funct3 == FUNCT3_WORD) begin
            ls_misaligned = |alu_result_i[1:0];
        end
    end

    assign excp_ferr  = ex_valid_i & held_i.ferr;
    assign excp_uerr  = ex_valid_i & held_i.uerr;
    assign excp_maif  = ex_valid_i & held_i.jump & (|alu_result_i[ALIGN_BITS-1:0]);
    assign excp_mala  = ex_valid_i & held_i.lq_wr & ls_misaligned;
    assign excp_masa  = ex_valid_i & held_i.sq_wr & ls_misaligned;
    assign excp_ecall = ex_valid_i & held_i.ecall;

    //----------------------------------------
    // cause and value
    //----------------------------------------
    always_comb begin
        trap_o.take = excp_ferr | excp_uerr | excp_maif |
                      excp_mala | excp_masa | excp_ecall;
        trap_o.cause = '0;
        trap_o.value = '0;

        // order sets the priority
        // value goes with the winning cause
        if (excp_ferr) begin
            trap_o.cause = CAUSE_INS_ACCESS_FAULT;
        end else if (excp_uerr) begin
            trap_o.cause = CAUSE_ILLEGAL_INS;
            trap_o.value = held_i.ins;
        end else if (excp_maif) begin
            trap_o.cause = CAUSE_INS_ADDR_MISALIGNED;
            trap_o.value = held_i.pc;
        end else if (excp_mala) begin
            trap_o.cause = CAUSE_LOAD_ADDR_MISALIGNED;
            trap_o.value = held_i.pc;
        end else if (excp_masa) begin
            trap_o.cause = CAUSE_STORE_ADDR_MISALIGNED;
            trap_o.value = held_i.pc;
        end else if (excp_ecall) begin
            trap_o.cause = CAUSE_ECALL_M;
        end
    end

endmodule

`default_nettype wire

// ==== ex_commit_ctrl.sv ====
//----------------------------------------
// start-of-flow tracking, qualification,
// commit gating, stall and write-back mux
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ex_commit_ctrl (
    input  wire                         clk_i,
    input  wire                         resetb_i,
    input  wire                         ins_sof_i,
    input  wire                         ins_valid_i,
    input  wire ex_pkg::ex_held_t       held_i,
    input  wire [ex_pkg::XLEN-1:0]      alu_result_i,
    input  wire                         cmp_i,
    input  wire                         trap_take_i,
    input  wire                         lsq_full_i,
    output logic                        ex_valid_o,
    output logic                        stage_en_o,
    output logic                        stall_o,
    output logic                        jump_o,
    output logic [ex_pkg::XLEN-1:0]     jump_addr_o,
    output ex_pkg::ex_wb_t              wb_o,
    output ex_pkg::ex_lsq_req_t         lsq_req_o
);
    import ex_pkg::*;

    logic sof_run_q;
    logic commit;
    logic redirect;

    //----------------------------------------
    // qualification
    //----------------------------------------
    assign ex_valid_o = held_i.valid & sof_run_q & (cmp_i | ~held_i.cond);
    assign commit     = ex_valid_o & ~trap_take_i;
    assign redirect   = (commit & held_i.jump) | trap_take_i;

    // queue back-pressure on a committing load or store
    assign stall_o    = commit & lsq_full_i & (held_i.lq_wr | held_i.sq_wr);
    assign stage_en_o = ~stall_o;

    // drop everything after a redirect until the next sof
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            sof_run_q <= 1'b1;
        end else if (stage_en_o) begin
            if (redirect) begin
                sof_run_q <= 1'b0;
            end else if (ins_valid_i & ins_sof_i) begin
                sof_run_q <= 1'b1;
            end
        end
    end

    //----------------------------------------
    // gated outputs
    //----------------------------------------
    assign jump_o      = stage_en_o & redirect;
    assign jump_addr_o = trap_take_i ? TRAP_VECTOR : alu_result_i;

    always_comb begin
        wb_o.wr        = stage_en_o & commit & held_i.regd_wr;
        wb_o.cncl_load = stage_en_o & ~commit & held_i.valid & held_i.lq_wr;
        wb_o.addr      = held_i.regd_addr;
        wb_o.data      = held_i.link ? held_i.pc_inc : alu_result_i;
    end

    always_comb begin
        lsq_req_o.lq_wr     = stage_en_o & commit & held_i.lq_wr;
        lsq_req_o.sq_wr     = stage_en_o & commit & held_i.sq_wr;
        lsq_req_o.funct3    = held_i.funct3;
        lsq_req_o.regd_addr = held_i.regd_addr;
        lsq_req_o.addr      = alu_result_i;
        lsq_req_o.data      = held_i.regs2_data;
    end

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
//----------------------------------------
// execute stage top level
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                         clk_i,
    input  wire                         resetb_i,
    input  wire ex_pkg::ex_ins_t        ids_ins_i,
    input  wire                         lsq_full_i,
    output logic                        ids_stall_o,
    output ex_pkg::ex_wb_t              wb_o,
    output ex_pkg::ex_lsq_req_t         lsq_req_o,
    output logic                        jump_o,
    output logic [ex_pkg::XLEN-1:0]     jump_addr_o,
    output ex_pkg::ex_trap_t            trap_o
);
    import ex_pkg::*;

    ex_held_t        held;
    logic [XLEN-1:0] alu_result;
    logic            cmp_true;
    logic            ex_valid;
    logic            stage_en;
    ex_trap_t        trap;

    assign trap_o = trap;

    ex_delay_stage u_delay_stage (
        .clk_i    (clk_i),
        .resetb_i (resetb_i),
        .en_i     (stage_en),
        .ins_i    (ids_ins_i),
        .held_o   (held)
    );

    // operands come straight from decode
    ex_alu u_alu (
        .clk_i       (clk_i),
        .resetb_i    (resetb_i),
        .en_i        (stage_en),
        .op_i        (ids_ins_i.alu_op),
        .left_i      (ids_ins_i.operand_left),
        .right_i     (ids_ins_i.operand_right),
        .cmp_left_i  (ids_ins_i.cmp_left),
        .cmp_right_i (ids_ins_i.cmp_right),
        .funct3_i    (ids_ins_i.funct3),
        .result_o    (alu_result),
        .cmp_o       (cmp_true)
    );

    ex_trap_unit u_trap_unit (
        .held_i       (held),
        .ex_valid_i   (ex_valid),
        .alu_result_i (alu_result),
        .trap_o       (trap)
    );

    ex_commit_ctrl u_commit_ctrl (
        .clk_i        (clk_i),
        .resetb_i     (resetb_i),
        .ins_sof_i    (ids_ins_i.sof),
        .ins_valid_i  (ids_ins_i.valid),
        .held_i       (held),
        .alu_result_i (alu_result),
        .cmp_i        (cmp_true),
        .trap_take_i  (trap.take),
        .lsq_full_i   (lsq_full_i),
        .ex_valid_o   (ex_valid),
        .stage_en_o   (stage_en),
        .stall_o      (ids_stall_o),
        .jump_o       (jump_o),
        .jump_addr_o  (jump_addr_o),
        .wb_o         (wb_o),
        .lsq_req_o    (lsq_req_o)
    );

endmodule

`default_nettype wire

// ==== ex_stage_asserts.sv ====
//----------------------------------------
// bound checks on stall gating, trap redirect
// and queue strobe exclusivity
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ex_stage_asserts (
    input  wire                         clk_i,
    input  wire                         resetb_i,
    input  wire                         stall_i,
    input  wire ex_pkg::ex_wb_t         wb_i,
    input  wire ex_pkg::ex_lsq_req_t    lsq_req_i,
    input  wire                         jump_i,
    input  wire ex_pkg::ex_trap_t       trap_i
);

    // running count of failed properties
    int fail_count = 0;

    // nothing leaves the stage while the queue pushes back
    no_write_in_stall: assert property (@(posedge clk_i) disable iff (!resetb_i)
        stall_i |-> !(wb_i.wr || lsq_req_i.lq_wr || lsq_req_i.sq_wr))
        else begin
            $error("write strobe high while the stage is stalled");
            fail_count++;
        end

    trap_redirects: assert property (@(posedge clk_i) disable iff (!resetb_i)
        trap_i.take |-> jump_i)
        else begin
            $error("trap taken without a redirect");
            fail_count++;
        end

    one_queue_strobe: assert property (@(posedge clk_i) disable iff (!resetb_i)
        !(lsq_req_i.lq_wr && lsq_req_i.sq_wr))
        else begin
            $error("load and store queue strobes high together");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== ex_checker.sv ====
//----------------------------------------
// reference model of the execute stage and
// output compare with mismatch counting
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ex_checker (
    input  wire                         clk_i,
    input  wire                         resetb_i,
    input  wire ex_pkg::ex_ins_t        ins_i,
    input  wire                         lsq_full_i,
    input  wire                         stall_i,
    input  wire ex_pkg::ex_wb_t         wb_i,
    input  wire ex_pkg::ex_lsq_req_t    lsq_req_i,
    input  wire                         jump_i,
    input  wire [ex_pkg::XLEN-1:0]      jump_addr_i,
    input  wire ex_pkg::ex_trap_t       trap_i,
    output int                          err_count_o,
    output int                          check_count_o
);
    import ex_pkg::*;

    typedef struct packed {
        logic            stall;
        logic            redirect;
        logic            jump;
        logic [XLEN-1:0] jump_addr;
        ex_wb_t          wb;
        ex_lsq_req_t     lsq;
        ex_trap_t        trap;
    } expect_t;

    ex_ins_t held;
    logic    run;
    expect_t exp;

    //----------------------------------------
    // reference function
    //----------------------------------------
    function automatic expect_t predict(input ex_ins_t ins, input logic run_st,
                                        input logic full);
        expect_t         e;
        logic [XLEN-1:0] res;
        logic            taken;
        logic            ex_ok;
        logic            mis;
        logic            commit;
        logic [5:0]      flt;
        e = '0;
        case (ins.alu_op)
            ALU_ADD: res = ins.operand_left + ins.operand_right;
            ALU_SUB: res = ins.operand_left - ins.operand_right;
            ALU_AND: res = ins.operand_left & ins.operand_right;
            ALU_OR:  res = ins.operand_left | ins.operand_right;
            ALU_XOR: res = ins.operand_left ^ ins.operand_right;
            default: res = XLEN'($signed(ins.operand_left) < $signed(ins.operand_right));
        endcase
        // branch conditions as in the base isa
        case (ins.funct3)
            3'd0:    taken = ins.cmp_left == ins.cmp_right;
            3'd1:    taken = ins.cmp_left != ins.cmp_right;
            3'd4:    taken = $signed(ins.cmp_left) < $signed(ins.cmp_right);
            3'd5:    taken = $signed(ins.cmp_left) >= $signed(ins.cmp_right);
            3'd6:    taken = ins.cmp_left < ins.cmp_right;
            3'd7:    taken = ins.cmp_left >= ins.cmp_right;
            default: taken = 1'b0;
        endcase
        ex_ok = ins.valid & run_st & (taken | ~ins.cond);
        mis   = (ins.funct3 == FUNCT3_HALF) ? res[0] :
                (ins.funct3 == FUNCT3_WORD) ? (res[1:0] != 2'b00) : 1'b0;
        // highest priority first
        flt = {ins.ferr, ins.uerr, ins.jump & (res[1:0] != 2'b00),
               (ins.zone == ZONE_LOADQ) & mis, (ins.zone == ZONE_STOREQ) & mis,
               ins.ecall} & {6{ex_ok}};
        e.trap.take  = |flt;
        e.trap.cause = flt[5] ? CAUSE_INS_ACCESS_FAULT :
                       flt[4] ? CAUSE_ILLEGAL_INS :
                       flt[3] ? CAUSE_INS_ADDR_MISALIGNED :
                       flt[2] ? CAUSE_LOAD_ADDR_MISALIGNED :
                       flt[1] ? CAUSE_STORE_ADDR_MISALIGNED : CAUSE_ECALL_M;
        // value belongs to the reported cause
        case (e.trap.cause)
            CAUSE_ILLEGAL_INS: e.trap.value = ins.ins;
            CAUSE_INS_ADDR_MISALIGNED,
            CAUSE_LOAD_ADDR_MISALIGNED,
            CAUSE_STORE_ADDR_MISALIGNED: e.trap.value = ins.pc;
            default: e.trap.value = '0;
        endcase
        commit = ex_ok & ~e.trap.take;
        e.stall = commit & full & ((ins.zone == ZONE_LOADQ) | (ins.zone == ZONE_STOREQ));
        e.redirect  = e.trap.take | (commit & ins.jump);
        e.jump      = e.redirect & ~e.stall;
        e.jump_addr = e.trap.take ? TRAP_VECTOR : res;
        e.wb.wr        = commit & ~e.stall & (ins.zone == ZONE_REGFILE);
        e.wb.cncl_load = ins.valid & (ins.zone == ZONE_LOADQ) & ~commit;
        e.wb.addr      = ins.regd_addr;
        e.wb.data      = ins.link ? ins.pc + XLEN'(INS_BYTES) : res;
        e.lsq.lq_wr     = commit & ~e.stall & (ins.zone == ZONE_LOADQ);
        e.lsq.sq_wr     = commit & ~e.stall & (ins.zone == ZONE_STOREQ);
        e.lsq.funct3    = ins.funct3;
        e.lsq.regd_addr = ins.regd_addr;
        e.lsq.addr      = res;
        e.lsq.data      = ins.regs2_data;
        return e;
    endfunction

    task automatic check_field(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] want);
        check_count_o++;
        if (got !== want) begin
            err_count_o++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    //----------------------------------------
    // compare at every rising edge
    //----------------------------------------
    always @(posedge clk_i) begin
        if (!resetb_i) begin
            held = '0;
            run  = 1'b1;
        end else begin
            exp = predict(held, run, lsq_full_i);
            check_field("stall", XLEN'(stall_i), XLEN'(exp.stall));
            check_field("jump", XLEN'(jump_i), XLEN'(exp.jump));
            if (exp.jump) begin
                check_field("jump_addr", jump_addr_i, exp.jump_addr);
            end
            check_field("wb.wr", XLEN'(wb_i.wr), XLEN'(exp.wb.wr));
            check_field("wb.cncl_load", XLEN'(wb_i.cncl_load), XLEN'(exp.wb.cncl_load));
            if (exp.wb.wr) begin
                check_field("wb.addr", XLEN'(wb_i.addr), XLEN'(exp.wb.addr));
                check_field("wb.data", wb_i.data, exp.wb.data);
            end
            check_field("lsq.lq_wr", XLEN'(lsq_req_i.lq_wr), XLEN'(exp.lsq.lq_wr));
            check_field("lsq.sq_wr", XLEN'(lsq_req_i.sq_wr), XLEN'(exp.lsq.sq_wr));
            if (exp.lsq.lq_wr | exp.lsq.sq_wr) begin
                check_field("lsq.addr", lsq_req_i.addr, exp.lsq.addr);
                check_field("lsq.data", lsq_req_i.data, exp.lsq.data);
                check_field("lsq.funct3", XLEN'(lsq_req_i.funct3), XLEN'(exp.lsq.funct3));
                check_field("lsq.regd", XLEN'(lsq_req_i.regd_addr), XLEN'(exp.lsq.regd_addr));
            end
            check_field("trap.take", XLEN'(trap_i.take), XLEN'(exp.trap.take));
            if (exp.trap.take) begin
                check_field("trap.cause", trap_i.cause, exp.trap.cause);
                check_field("trap.value", trap_i.value, exp.trap.value);
            end
            // the instruction taken with a redirect is stale even with sof
            if (!exp.stall) begin
                if (exp.redirect) begin
                    run = 1'b0;
                end else if (ins_i.valid & ins_i.sof) begin
                    run = 1'b1;
                end
                held = ins_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_ex_stage.sv ====
//----------------------------------------
// testbench top with clock, reset, random
// instruction stream and closing report
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    localparam int NUM_INS      = 300;
    localparam int RESET_CYCLES = 8;
    // room for a few stall cycles per instruction
    localparam int CYCLE_LIMIT  = NUM_INS * 6 + 200;

    logic            clk;
    logic            resetb;
    ex_ins_t         ids_ins;
    logic            lsq_full;
    logic            ids_stall;
    ex_wb_t          wb;
    ex_lsq_req_t     lsq_req;
    logic            jump;
    logic [XLEN-1:0] jump_addr;
    ex_trap_t        trap;
    logic            accepted;
    logic [31:0]     lfsr_q;
    logic [XLEN-1:0] pc_q;
    int              cycle_count;
    int              err_count;
    int              check_count;

    ex_stage UUT (
        .clk_i       (clk),
        .resetb_i    (resetb),
        .ids_ins_i   (ids_ins),
        .lsq_full_i  (lsq_full),
        .ids_stall_o (ids_stall),
        .wb_o        (wb),
        .lsq_req_o   (lsq_req),
        .jump_o      (jump),
        .jump_addr_o (jump_addr),
        .trap_o      (trap)
    );

    ex_checker u_checker (
        .clk_i         (clk),
        .resetb_i      (resetb),
        .ins_i         (ids_ins),
        .lsq_full_i    (lsq_full),
        .stall_i       (ids_stall),
        .wb_i          (wb),
        .lsq_req_i     (lsq_req),
        .jump_i        (jump),
        .jump_addr_i   (jump_addr),
        .trap_i        (trap),
        .err_count_o   (err_count),
        .check_count_o (check_count)
    );

    bind ex_stage ex_stage_asserts u_asserts (
        .clk_i     (clk_i),
        .resetb_i  (resetb_i),
        .stall_i   (ids_stall_o),
        .wb_i      (wb_o),
        .lsq_req_i (lsq_req_o),
        .jump_i    (jump_o),
        .trap_i    (trap_o)
    );

    always #20 clk = ~clk;

    // stall seen at the edge tells the driver to move on
    always @(posedge clk) begin
        accepted    <= !ids_stall;
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles, checks: %0d, mismatches: %0d",
                     cycle_count, check_count, err_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    //----------------------------------------
    // random instruction
    //----------------------------------------
    function automatic ex_ins_t make_ins();
        ex_ins_t     ins;
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [31:0] r;
        ins               = '0;
        kind              = 3'(rand_bits(3));
        r                 = rand_bits(4);
        ins.valid         = (kind != 3'd7);
        ins.sof           = (rand_bits(2) == 0);
        ins.pc            = pc_q;
        ins.ins           = rand_bits(32);
        ins.regd_addr     = 5'(rand_bits(5));
        ins.regs2_data    = rand_bits(32);
        ins.cmp_left      = XLEN'($signed(4'(rand_bits(4))));
        ins.cmp_right     = r[0] ? ins.cmp_left : XLEN'($signed(4'(rand_bits(4))));
        ins.alu_op        = ALU_ADD;
        // aligned base with an occasional odd offset
        ins.operand_left  = rand_bits(30) << 2;
        ins.operand_right = (rand_bits(2) == 0) ? XLEN'(rand_bits(2)) : '0;
        f3                = 3'(rand_bits(3));
        if (f3[2:1] == 2'b01) begin
            f3[2] = 1'b1;
        end
        ins.funct3 = (r[2:1] == 2'b11) ? FUNCT3_WORD : {1'b0, r[2:1]};
        case (kind)
            3'd0, 3'd1: begin
                ins.zone          = ZONE_REGFILE;
                ins.alu_op        = ex_alu_op_e'(3'(r % 6));
                ins.operand_left  = rand_bits(32);
                ins.operand_right = rand_bits(32);
                ins.cond          = (kind == 3'd1);
                ins.funct3        = f3;
            end
            3'd2: begin
                ins.jump   = 1'b1;
                ins.cond   = 1'b1;
                ins.funct3 = f3;
            end
            3'd3: begin
                ins.jump = 1'b1;
                ins.link = 1'b1;
                ins.zone = ZONE_REGFILE;
            end
            3'd4:    ins.zone = ZONE_LOADQ;
            3'd5:    ins.zone = ZONE_STOREQ;
            3'd6: begin
                ins.ferr  = r[1];
                ins.uerr  = r[2];
                ins.ecall = r[3];
                ins.jump  = r[0];
                ins.zone  = ex_zone_e'(2'(rand_bits(2)));
            end
            default: ins.valid = 1'b0;
        endcase
        return ins;
    endfunction

    task automatic run_stream();
        int   sent;
        logic done;
        sent = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            lsq_full = 1'(rand_bits(1));
            if (accepted) begin
                if (sent < NUM_INS) begin
                    ids_ins = make_ins();
                    pc_q    = pc_q + XLEN'(INS_BYTES);
                end else if (sent == NUM_INS) begin
                    // trailing bubble pushes the last instruction out
                    ids_ins = '0;
                end else begin
                    done = 1'b1;
                end
                sent++;
            end
        end
    endtask

    initial begin
        lfsr_q   = 32'd92878;
        pc_q     = 32'h0000_1000;
        clk      = 1'b0;
        resetb   = 1'b0;
        ids_ins  = '0;
        lsq_full = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        resetb = 1'b1;
        run_stream();
        $display("checks: %0d, mismatches: %0d, assertion failures: %0d",
                 check_count, err_count, UUT.u_asserts.fail_count);
        if (err_count == 0 && UUT.u_asserts.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
ex_pkg.sv
ex_alu.sv
ex_delay_stage.sv
ex_trap_unit.sv
ex_commit_ctrl.sv
ex_stage.sv
ex_stage_asserts.sv
ex_checker.sv
tb_ex_stage.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_ex_stage
FILELIST  := sources.f
SIM_ARGS  := +verilator+error+limit+1000

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)
